// ==== source/ttlBridgePkg.sv ====
package ttlBridgePkg;

  // TTL bus widths
  localparam int AddrWidth = 16;
  localparam int DataWidth = 8;

  // Master command interface widths
  localparam int MstAddrWidth = 32;
  localparam int MstDataWidth = 32;

  // Request queue
  localparam int FifoDepth    = 4;
  localparam int FifoPtrWidth = $clog2(FifoDepth);

  // Interrupt vector layout
  localparam int IntrWidth    = 4;
  localparam int IntrRead     = 0;
  localparam int IntrWrite    = 1;
  localparam int IntrError    = 2;
  localparam int IntrOverflow = 3;

  typedef enum logic {
    opRead  = 1'b0,
    opWrite = 1'b1
  } requestOp;

  typedef struct packed {
    requestOp               op;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   data;
  } busRequest;

  typedef enum logic [1:0] {
    stIdle    = 2'b00,
    stRequest = 2'b01,
    stDone    = 2'b10
  } engineState;

  typedef struct packed {
    logic                    rdReq;
    logic                    wrReq;
    logic [MstAddrWidth-1:0] addr;
    logic [MstDataWidth-1:0] wrData;
  } mstCommand;

  typedef struct packed {
    logic                    cmplt;
    logic                    error;
    logic [MstDataWidth-1:0] rdData;
  } mstResponse;

endpackage

// ==== source/ttlBusFrontEnd.sv ====
`timescale 1ns/1ps

module ttlBusFrontEnd (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 nChipEnable,
  input  logic                                 nOutputEnable,
  input  logic                                 nWriteEnable,
  input  logic [ttlBridgePkg::AddrWidth-1:0]   address,
  input  logic [ttlBridgePkg::DataWidth-1:0]   dataIn,
  input  logic                                 full,
  output logic                                 pushValid,
  output ttlBridgePkg::busRequest              pushData,
  output logic                                 overflow,
  output logic                                 dataOutEnable
);

  // Two-flop synchronizers with bit 1 as the usable copy
  logic [1:0] ceSync;
  logic [1:0] oeSync;
  logic [1:0] weSync;
  logic [ttlBridgePkg::AddrWidth-1:0] addrMeta;
  logic [ttlBridgePkg::AddrWidth-1:0] addrSync;
  logic [ttlBridgePkg::DataWidth-1:0] dataMeta;
  logic [ttlBridgePkg::DataWidth-1:0] dataSync;

  // Edge detection
  logic oePrev;
  logic wePrev;
  logic writeDone;
  logic readStart;

  logic strobe;
  ttlBridgePkg::busRequest request;

  // Write completes on the rising edge of write enable
  assign writeDone = ~ceSync[1] & weSync[1] & ~wePrev;
  // Read starts on the falling edge of output enable, write enable idle
  assign readStart = ~ceSync[1] & weSync[1] & oePrev & ~oeSync[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ceSync <= 2'b11;
      oeSync <= 2'b11;
      weSync <= 2'b11;
      oePrev <= 1'b1;
      wePrev <= 1'b1;
      strobe <= 1'b0;
    end else begin
      ceSync <= {ceSync[0], nChipEnable};
      oeSync <= {oeSync[0], nOutputEnable};
      weSync <= {weSync[0], nWriteEnable};
      oePrev <= oeSync[1];
      wePrev <= weSync[1];
      strobe <= writeDone | readStart;
    end
  end

  // Bus payload follows the control pins through the same two stages
  always_ff @(posedge clk) begin
    addrMeta <= address;
    addrSync <= addrMeta;
    dataMeta <= dataIn;
    dataSync <= dataMeta;
  end

  // A write end and a read start in one cycle keeps only the write
  always_ff @(posedge clk) begin
    if (writeDone | readStart) begin
      request.op   <= writeDone ? ttlBridgePkg::opWrite : ttlBridgePkg::opRead;
      request.addr <= addrSync;
      request.data <= dataSync;
    end
  end

  // Full is sampled in the push cycle itself
  assign pushValid = strobe & ~full;
  assign overflow  = strobe & full;
  assign pushData  = request;

  // Bridge drives the host bus only during a plain read
  assign dataOutEnable = ~nChipEnable & ~nOutputEnable & nWriteEnable;

  pushOrOverflow: assert property (
    @(posedge clk) disable iff (!rst_n) !(pushValid && overflow)
  ) else $error("pushValid and overflow high in the same cycle");

endmodule

// ==== source/requestFifo.sv ====
`timescale 1ns/1ps

module requestFifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    pushValid,
  input  ttlBridgePkg::busRequest pushData,
  input  logic                    pop,
  output ttlBridgePkg::busRequest headData,
  output logic                    full,
  output logic                    empty
);

  ttlBridgePkg::busRequest mem [ttlBridgePkg::FifoDepth];

  logic [ttlBridgePkg::FifoPtrWidth-1:0] wrPtr;
  logic [ttlBridgePkg::FifoPtrWidth-1:0] rdPtr;
  logic [ttlBridgePkg::FifoPtrWidth:0]   count;

  always_ff @(posedge clk) begin
    if (pushValid) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushValid) begin
        wrPtr <= (wrPtr == ttlBridgePkg::FifoDepth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ttlBridgePkg::FifoDepth - 1) ? '0 : rdPtr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({pushValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry is visible without a pop
  assign headData = mem[rdPtr];
  assign full     = (count == ttlBridgePkg::FifoDepth);
  assign empty    = (count == '0);

  noPushWhenFull: assert property (
    @(posedge clk) disable iff (!rst_n) pushValid |-> !full
  ) else $error("push into a full request queue");

  noPopWhenEmpty: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> !empty
  ) else $error("pop from an empty request queue");

endmodule

// ==== source/busMasterEngine.sv ====
`timescale 1ns/1ps

module busMasterEngine (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  empty,
  input  ttlBridgePkg::busRequest               headData,
  input  logic [ttlBridgePkg::MstAddrWidth-1:0] mappedAddress,
  input  ttlBridgePkg::mstResponse              mstRsp,
  input  logic                                  overflow,
  input  logic [ttlBridgePkg::IntrWidth-1:0]    intrEnable,
  input  logic [ttlBridgePkg::IntrWidth-1:0]    intrAck,
  output logic                                  pop,
  output ttlBridgePkg::mstCommand               mstCmd,
  output logic [ttlBridgePkg::DataWidth-1:0]    dataOut,
  output logic                                  busyEngine,
  output logic [ttlBridgePkg::IntrWidth-1:0]    intrStatus,
  output logic                                  interrupt
);

  localparam int AddrPad = ttlBridgePkg::MstAddrWidth - ttlBridgePkg::AddrWidth;
  localparam int DataPad = ttlBridgePkg::MstDataWidth - ttlBridgePkg::DataWidth;

  ttlBridgePkg::engineState state;
  ttlBridgePkg::requestOp   curOp;

  logic                                  rdReq;
  logic                                  wrReq;
  logic [ttlBridgePkg::MstAddrWidth-1:0] cmdAddr;
  logic [ttlBridgePkg::MstDataWidth-1:0] cmdData;
  logic [ttlBridgePkg::MstAddrWidth-1:0] reqAddr;
  logic [ttlBridgePkg::MstDataWidth-1:0] reqData;

  logic [ttlBridgePkg::DataWidth-1:0] rspByte;
  logic                               rspError;
  logic [ttlBridgePkg::DataWidth-1:0] readData;
  logic [ttlBridgePkg::IntrWidth-1:0] setBits;

  // Pop only from idle, so one request is in flight at a time
  assign pop = (state == ttlBridgePkg::stIdle) && !empty;

  // Bus address is an offset into the mapped window
  assign reqAddr = mappedAddress + {{AddrPad{1'b0}}, headData.addr};
  assign reqData = {{DataPad{1'b0}}, headData.data};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ttlBridgePkg::stIdle;
      rdReq    <= 1'b0;
      wrReq    <= 1'b0;
      readData <= '0;
    end else begin
      case (state)
        ttlBridgePkg::stIdle: begin
          if (!empty) begin
            state <= ttlBridgePkg::stRequest;
            rdReq <= (headData.op == ttlBridgePkg::opRead);
            wrReq <= (headData.op == ttlBridgePkg::opWrite);
          end
        end
        ttlBridgePkg::stRequest: begin
          // Request level held until the slave reports completion
          if (mstRsp.cmplt) begin
            state <= ttlBridgePkg::stDone;
            rdReq <= 1'b0;
            wrReq <= 1'b0;
          end
        end
        ttlBridgePkg::stDone: begin
          state <= ttlBridgePkg::stIdle;
          if (curOp == ttlBridgePkg::opRead) begin
            readData <= rspByte;
          end
        end
        default: state <= ttlBridgePkg::stIdle;
      endcase
    end
  end

  // Command payload and captured response
  always_ff @(posedge clk) begin
    if (pop) begin
      curOp   <= headData.op;
      cmdAddr <= reqAddr;
      cmdData <= reqData;
    end
    if ((state == ttlBridgePkg::stRequest) && mstRsp.cmplt) begin
      // Slave returns the byte in the low lane
      rspByte  <= mstRsp.rdData[ttlBridgePkg::DataWidth-1:0];
      rspError <= mstRsp.error;
    end
  end

  assign mstCmd = '{rdReq: rdReq, wrReq: wrReq, addr: cmdAddr, wrData: cmdData};

  always_comb begin
    setBits = '0;
    if (state == ttlBridgePkg::stDone) begin
      setBits[ttlBridgePkg::IntrRead]  = (curOp == ttlBridgePkg::opRead);
      setBits[ttlBridgePkg::IntrWrite] = (curOp == ttlBridgePkg::opWrite);
      setBits[ttlBridgePkg::IntrError] = rspError;
    end
    setBits[ttlBridgePkg::IntrOverflow] = overflow;
  end

  // New events win over an acknowledge in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      intrStatus <= '0;
    end else begin
      intrStatus <= (intrStatus & ~intrAck) | setBits;
    end
  end

  assign interrupt  = |(intrStatus & intrEnable);
  assign dataOut    = readData;
  assign busyEngine = (state != ttlBridgePkg::stIdle);

  oneRequestKind: assert property (
    @(posedge clk) disable iff (!rst_n) !(mstCmd.rdReq && mstCmd.wrReq)
  ) else $error("rdReq and wrReq high together");

  // Address and data stay put while the slave is still working
  cmdStable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == ttlBridgePkg::stRequest && !mstRsp.cmplt) |=> $stable(mstCmd)
  ) else $error("master command changed before completion");

endmodule

// ==== source/ttlMemoryBridge.sv ====
`timescale 1ns/1ps

module ttlMemoryBridge (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  nChipEnable,
  input  logic                                  nOutputEnable,
  input  logic                                  nWriteEnable,
  input  logic [ttlBridgePkg::AddrWidth-1:0]    address,
  input  logic [ttlBridgePkg::DataWidth-1:0]    dataIn,
  input  logic [ttlBridgePkg::MstAddrWidth-1:0] mappedAddress,
  input  logic [ttlBridgePkg::IntrWidth-1:0]    intrEnable,
  input  logic [ttlBridgePkg::IntrWidth-1:0]    intrAck,
  input  ttlBridgePkg::mstResponse              mstRsp,
  output logic [ttlBridgePkg::DataWidth-1:0]    dataOut,
  output logic                                  dataOutEnable,
  output ttlBridgePkg::mstCommand               mstCmd,
  output logic                                  interrupt,
  output logic [ttlBridgePkg::IntrWidth-1:0]    intrStatus,
  output logic                                  busy
);

  logic                    pushValid;
  ttlBridgePkg::busRequest pushData;
  logic                    full;
  logic                    overflow;
  logic                    empty;
  ttlBridgePkg::busRequest headData;
  logic                    pop;
  logic                    busyEngine;

  ttlBusFrontEnd ttlBusFrontEnd_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .nWriteEnable  (nWriteEnable),
    .address       (address),
    .dataIn        (dataIn),
    .full          (full),
    .pushValid     (pushValid),
    .pushData      (pushData),
    .overflow      (overflow),
    .dataOutEnable (dataOutEnable)
  );

  requestFifo requestFifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .pushValid (pushValid),
    .pushData  (pushData),
    .pop       (pop),
    .headData  (headData),
    .full      (full),
    .empty     (empty)
  );

  busMasterEngine busMasterEngine_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .empty         (empty),
    .headData      (headData),
    .mappedAddress (mappedAddress),
    .mstRsp        (mstRsp),
    .overflow      (overflow),
    .intrEnable    (intrEnable),
    .intrAck       (intrAck),
    .pop           (pop),
    .mstCmd        (mstCmd),
    .dataOut       (dataOut),
    .busyEngine    (busyEngine),
    .intrStatus    (intrStatus),
    .interrupt     (interrupt)
  );

  // Work is pending while anything is queued or in flight
  assign busy = ~empty | busyEngine;

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

endmodule

// ==== tb/ttlMemoryBridgeTb.sv ====
`timescale 1ns/1ps

module ttlMemoryBridgeTb;

  localparam int ResetCycles = 5;
  localparam int NumWrites   = 16;
  localparam int PoolSize    = 6;
  localparam int HostWidth   = 4;
  localparam int FastWidth   = 2;
  localparam int MaxDelay    = 4;
  localparam int StallDelay  = 40;
  localparam int StallWrites = ttlBridgePkg::FifoDepth + 3;
  // Host cycle, front-end sync, engine overhead and worst slave latency
  localparam int OpCycles    = 2 * HostWidth + 1 + 3 + 4 + MaxDelay;
  localparam int CycleLimit  = 2 * (ResetCycles + 25
                                    + (NumWrites + PoolSize + 6) * OpCycles
                                    + StallWrites * OpCycles
                                    + (ttlBridgePkg::FifoDepth + 1) * (StallDelay + 4));

  typedef struct packed {
    logic        isWrite;
    logic [31:0] addr;
    logic [31:0] word;
  } expectEntry;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  nChipEnable;
  logic                                  nOutputEnable;
  logic                                  nWriteEnable;
  logic [ttlBridgePkg::AddrWidth-1:0]    address;
  logic [ttlBridgePkg::DataWidth-1:0]    dataIn;
  logic [ttlBridgePkg::MstAddrWidth-1:0] mappedAddress;
  logic [ttlBridgePkg::IntrWidth-1:0]    intrEnable;
  logic [ttlBridgePkg::IntrWidth-1:0]    intrAck;
  ttlBridgePkg::mstResponse              mstRsp;
  logic [ttlBridgePkg::DataWidth-1:0]    dataOut;
  logic                                  dataOutEnable;
  ttlBridgePkg::mstCommand               mstCmd;
  logic                                  interrupt;
  logic [ttlBridgePkg::IntrWidth-1:0]    intrStatus;
  logic                                  busy;

  expectEntry  expQ [$];
  expectEntry  headExpect;
  logic [7:0]  refMem [0:65535];
  logic [31:0] slaveMem [0:65535];
  logic [15:0] addrPool [PoolSize];
  logic [31:0] hostRng;
  logic [31:0] slaveRng;
  logic [31:0] errorAddr;
  logic        stallMode;
  logic        errorArmed;
  logic        maskWatch;
  int          pick;
  int          stallStart;
  int          cycleCount    = 0;
  int          issuedCount   = 0;
  int          mismatchCount = 0;
  int          failureCount  = 0;

  clockGen clockGen_inst (.clk(clk));

  ttlMemoryBridge ttlMemoryBridge_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .nWriteEnable  (nWriteEnable),
    .address       (address),
    .dataIn        (dataIn),
    .mappedAddress (mappedAddress),
    .intrEnable    (intrEnable),
    .intrAck       (intrAck),
    .mstRsp        (mstRsp),
    .dataOut       (dataOut),
    .dataOutEnable (dataOutEnable),
    .mstCmd        (mstCmd),
    .interrupt     (interrupt),
    .intrStatus    (intrStatus),
    .busy          (busy)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected master command for the next request in issue order
  function automatic expectEntry expectedMaster(input logic isWrite,
                                                input logic [15:0] busAddr,
                                                input logic [7:0] busData);
    expectEntry e;
    e.isWrite = isWrite;
    e.addr    = mappedAddress + {16'h0000, busAddr};
    if (isWrite) begin
      refMem[busAddr] = busData;
      e.word = {24'h000000, busData};
    end else begin
      e.word = {24'h000000, refMem[busAddr]};
    end
    return e;
  endfunction

  task automatic compareValues(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH %s actual=0x%0h expected=0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic reportFailure(input string what);
    failureCount++;
    $display("FAILURE at %0t: %s", $time, what);
  endtask

  task automatic checkAllIssued(input string testName);
    if (expQ.size() != 0) begin
      reportFailure($sformatf("%s: %0d expected commands never issued", testName, expQ.size()));
      expQ.delete();
    end
  endtask

  // Host tasks start and end on a falling edge
  task automatic hostWrite(input logic [15:0] addr, input logic [7:0] data, input int width);
    nChipEnable  = 1'b0;
    nWriteEnable = 1'b0;
    address      = addr;
    dataIn       = data;
    repeat (width) @(negedge clk);
    nWriteEnable = 1'b1;
    repeat (width) @(negedge clk);
    nChipEnable = 1'b1;
    @(negedge clk);
  endtask

  task automatic issueWrite(input logic [15:0] addr, input logic [7:0] data, input int width);
    expQ.push_back(expectedMaster(1'b1, addr, data));
    hostWrite(addr, data, width);
  endtask

  task automatic waitIdle();
    // Front end needs three cycles before a strobe reaches the queue
    repeat (4) @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
  endtask

  task automatic issueRead(input logic [15:0] addr);
    expectEntry e;
    e = expectedMaster(1'b0, addr, 8'h00);
    expQ.push_back(e);
    nChipEnable   = 1'b0;
    nOutputEnable = 1'b0;
    address       = addr;
    waitIdle();
    compareValues("dataOutEnable", dataOutEnable, 1);
    compareValues("dataOut", dataOut, e.word);
    nOutputEnable = 1'b1;
    nChipEnable   = 1'b1;
    @(negedge clk);
  endtask

  task automatic pulseAck(input logic [ttlBridgePkg::IntrWidth-1:0] bits);
    intrAck = bits;
    @(negedge clk);
    intrAck = '0;
    @(negedge clk);
  endtask

  // Slave memory model answering one command at a time
  initial begin
    int          delay;
    logic [31:0] offset;
    mstRsp = '0;
    forever begin
      @(negedge clk);
      if (mstCmd.rdReq === 1'b1 || mstCmd.wrReq === 1'b1) begin
        slaveRng = xorshift32(slaveRng);
        delay = stallMode ? StallDelay : 1 + int'(slaveRng % MaxDelay);
        repeat (delay - 1) @(negedge clk);
        offset = mstCmd.addr - mappedAddress;
        mstRsp.cmplt = 1'b1;
        mstRsp.error = errorArmed && (mstCmd.addr == errorAddr);
        if (mstCmd.wrReq) begin
          slaveMem[offset[15:0]] = mstCmd.wrData;
          mstRsp.rdData = '0;
        end else begin
          mstRsp.rdData = slaveMem[offset[15:0]];
        end
        @(negedge clk);
        mstRsp = '0;
      end
    end
  end

  // Sampled in the middle of the low phase away from both clock edges
  always begin
    @(negedge clk);
    #2;
    if (maskWatch && interrupt) begin
      reportFailure("interrupt raised while every status bit was masked");
    end
    if (mstRsp.cmplt && (mstCmd.rdReq || mstCmd.wrReq)) begin
      issuedCount++;
      if (expQ.size() == 0) begin
        reportFailure("master command issued with nothing expected");
      end else begin
        headExpect = expQ.pop_front();
        compareValues("mstCmd.wrReq", mstCmd.wrReq, headExpect.isWrite);
        compareValues("mstCmd.rdReq", mstCmd.rdReq, !headExpect.isWrite);
        compareValues("mstCmd.addr", mstCmd.addr, headExpect.addr);
        if (headExpect.isWrite) begin
          compareValues("mstCmd.wrData", mstCmd.wrData, headExpect.word);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      reportFailure("run did not finish within the cycle limit");
      $display("errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    rst_n         = 1'b0;
    nChipEnable   = 1'b1;
    nOutputEnable = 1'b1;
    nWriteEnable  = 1'b1;
    address       = '0;
    dataIn        = '0;
    mappedAddress = 32'h8001_F000;
    intrEnable    = '0;
    intrAck       = '0;
    hostRng       = 32'd37;
    slaveRng      = 32'd37;
    errorAddr     = '0;
    stallMode     = 1'b0;
    errorArmed    = 1'b0;
    maskWatch     = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle outputs after reset
    compareValues("mstCmd.rdReq", mstCmd.rdReq, 0);
    compareValues("mstCmd.wrReq", mstCmd.wrReq, 0);
    compareValues("interrupt", interrupt, 0);
    compareValues("busy", busy, 0);
    compareValues("intrStatus", intrStatus, 0);
    compareValues("dataOutEnable", dataOutEnable, 0);
    nChipEnable = 1'b0;
    @(negedge clk);
    compareValues("dataOutEnable", dataOutEnable, 0);
    // Output enable during a write cycle keeps the bus released
    nWriteEnable  = 1'b0;
    nOutputEnable = 1'b0;
    @(negedge clk);
    compareValues("dataOutEnable", dataOutEnable, 0);
    nChipEnable = 1'b1;
    @(negedge clk);
    compareValues("dataOutEnable", dataOutEnable, 0);
    nWriteEnable  = 1'b1;
    nOutputEnable = 1'b1;
    repeat (4) @(negedge clk);
    compareValues("busy", busy, 0);

    // Random writes over a small address pool
    for (int i = 0; i < PoolSize; i++) begin
      hostRng = xorshift32(hostRng);
      addrPool[i] = hostRng[15:0];
    end
    for (int i = 0; i < NumWrites; i++) begin
      hostRng = xorshift32(hostRng);
      pick = (i < PoolSize) ? i : int'(hostRng[23:16] % PoolSize);
      issueWrite(addrPool[pick], hostRng[7:0], HostWidth);
    end
    waitIdle();
    checkAllIssued("random writes");

    for (int i = 0; i < PoolSize; i++) begin
      issueRead(addrPool[PoolSize - 1 - i]);
    end
    checkAllIssued("read back");

    // Interrupt status, acknowledge and masking
    pulseAck('1);
    compareValues("intrStatus", intrStatus, 0);
    intrEnable[ttlBridgePkg::IntrRead]  = 1'b1;
    intrEnable[ttlBridgePkg::IntrWrite] = 1'b1;
    issueWrite(addrPool[0], 8'hC3, HostWidth);
    waitIdle();
    compareValues("intrStatus", intrStatus, 1 << ttlBridgePkg::IntrWrite);
    compareValues("interrupt", interrupt, 1);
    pulseAck(1 << ttlBridgePkg::IntrWrite);
    compareValues("intrStatus", intrStatus, 0);
    compareValues("interrupt", interrupt, 0);
    issueRead(addrPool[0]);
    compareValues("intrStatus", intrStatus, 1 << ttlBridgePkg::IntrRead);
    compareValues("interrupt", interrupt, 1);
    pulseAck('1);
    intrEnable = '0;
    maskWatch  = 1'b1;
    issueWrite(addrPool[1], 8'h3C, HostWidth);
    waitIdle();
    compareValues("intrStatus", intrStatus, 1 << ttlBridgePkg::IntrWrite);
    compareValues("interrupt", interrupt, 0);
    pulseAck('1);
    maskWatch  = 1'b0;
    intrEnable = '1;
    checkAllIssued("interrupts");

    // Error response still completes the command
    errorAddr  = mappedAddress + 32'h0000_0BAD;
    errorArmed = 1'b1;
    issueWrite(16'h0BAD, 8'hE7, HostWidth);
    waitIdle();
    errorArmed = 1'b0;
    compareValues("intrStatus", intrStatus,
                  (1 << ttlBridgePkg::IntrError) | (1 << ttlBridgePkg::IntrWrite));
    compareValues("interrupt", interrupt, 1);
    checkAllIssued("error response");
    pulseAck('1);

    // Stalled slave holds one request in flight while the queue fills
    stallMode  = 1'b1;
    stallStart = issuedCount;
    for (int i = 0; i < StallWrites; i++) begin
      hostRng = xorshift32(hostRng);
      if (i <= ttlBridgePkg::FifoDepth) begin
        issueWrite(16'h4000 + i[15:0], hostRng[7:0], FastWidth);
      end else begin
        hostWrite(16'h4000 + i[15:0], hostRng[7:0], FastWidth);
      end
    end
    waitIdle();
    stallMode = 1'b0;
    compareValues("intrStatus overflow bit", intrStatus[ttlBridgePkg::IntrOverflow], 1);
    compareValues("issued commands", issuedCount - stallStart, ttlBridgePkg::FifoDepth + 1);
    checkAllIssued("stalled slave");

    $display("errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== ttlMemoryBridge.f ====
source/ttlBridgePkg.sv
source/ttlBusFrontEnd.sv
source/requestFifo.sv
source/busMasterEngine.sv
source/ttlMemoryBridge.sv
tb/clockGen.sv
tb/ttlMemoryBridgeTb.sv

// ==== Bender.yml ====
package:
  name: ttl_memory_bridge

sources:
  # RTL
  - files:
      - source/ttlBridgePkg.sv
      - source/ttlBusFrontEnd.sv
      - source/requestFifo.sv
      - source/busMasterEngine.sv
      - source/ttlMemoryBridge.sv

  # Testbench
  - target: test
    files:
      - tb/clockGen.sv
      - tb/ttlMemoryBridgeTb.sv
